//--- verilog.f
src/replay_pkg.sv
src/replay_regs.sv
src/capture_writer.sv
src/pcap_buffer.sv
src/replay_reader.sv
src/replay_out_fifo.sv
src/pcap_replay_top.sv
test/tb_pcap_replay.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the capture and replay testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f \
  --top-module tb_pcap_replay -o tb_pcap_replay
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit $build_status
fi

./obj_dir/tb_pcap_replay
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "Simulation failed with status $sim_status"
  exit $sim_status
fi

exit 0

//--- test/tb_pcap_replay.sv
// Testbench for the capture and replay engine
// Random frames and back-pressure, checked against a queue model of the capture
`timescale 1ns/1ps

module tb_pcap_replay;
  import replay_pkg::*;

  localparam int         BUF_ADDR_W  = 6;
  localparam int         FIFO_DEPTH  = 8;
  localparam logic [7:0] CAP_PORT    = 8'h02;
  localparam logic [7:0] DST_PORT    = 8'h01;
  localparam int         WAIT_CYCLES = 2000;

  logic         axis_aclk;
  logic         axis_aresetn;
  reg_write_t   cfg;
  stream_beat_t s_beat;
  logic         s_valid;
  stream_beat_t m_beat;
  logic         m_valid;
  logic         m_ready;
  logic         replay_active;

  stream_beat_t cap_q[$];
  stream_beat_t exp_q[$];
  bit           random_ready;
  bit           stall_out;
  int           beats_out;
  int           beats_expected;

  pcap_replay_top #(
    .BUF_ADDR_W       (BUF_ADDR_W),
    .FIFO_DEPTH       (FIFO_DEPTH),
    .CAPTURE_SRC_PORT (CAP_PORT),
    .REPLAY_DST_PORT  (DST_PORT)
  ) pcap_replay_top_i (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .cfg           (cfg),
    .s_beat        (s_beat),
    .s_valid       (s_valid),
    .m_beat        (m_beat),
    .m_valid       (m_valid),
    .m_ready       (m_ready),
    .replay_active (replay_active)
  );

  initial begin
    axis_aclk = 1'b0;
    forever begin
      #50 axis_aclk = ~axis_aclk;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("error %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // Advance one cycle, then drive a fresh m_ready just after the edge
  task automatic next_cycle();
    @(posedge axis_aclk);
    #1;
    m_ready = stall_out ? 1'b0 : (random_ready ? ($urandom % 3 != 0) : 1'b1);
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
    cfg.valid = 1'b1;
    cfg.addr  = addr;
    cfg.data  = data;
    next_cycle();
    cfg = '0;
  endtask

  task automatic send_frame(input logic [7:0] src, input int len);
    stream_beat_t beat;
    int           i;
    for (i = 0; i < len; i++) begin
      beat.data = {$urandom, $urandom};
      beat.keep = KEEP_W'($urandom);
      beat.user = {8'($urandom), src};
      beat.last = (i == len - 1);
      s_beat    = beat;
      s_valid   = 1'b1;
      if (src == CAP_PORT) begin
        cap_q.push_back(beat);
      end
      next_cycle();
      if ($urandom % 4 == 0) begin
        s_valid = 1'b0;
        next_cycle();
      end
    end
    s_valid = 1'b0;
  endtask

  // First frame always matches so the writer leaves idle before the done write
  task automatic capture(input int frames);
    logic [7:0] src;
    int         f;
    cap_q.delete();
    for (f = 0; f < frames; f++) begin
      if (f == 0 || $urandom % 2 == 0) begin
        src = CAP_PORT;
      end else begin
        src = 8'h03 + 8'($urandom % 4);
      end
      send_frame(src, 1 + int'($urandom % 4));
    end
    next_cycle();
    write_reg(REG_WR_DONE, 32'd1);
    next_cycle();
    next_cycle();
  endtask

  task automatic wait_active(input logic level, input string what);
    int n;
    n = 0;
    while (replay_active !== level) begin
      if (n == WAIT_CYCLES) begin
        abort_run($sformatf("timeout waiting for %s", what));
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic replay(input int passes);
    stream_beat_t beat;
    int           n;
    for (int p = 0; p < passes; p++) begin
      foreach (cap_q[i]) begin
        beat            = cap_q[i];
        beat.user[15:8] = DST_PORT;
        exp_q.push_back(beat);
        beats_expected++;
      end
    end
    write_reg(REG_REPLAY_COUNT, 32'(passes));
    write_reg(REG_START, 32'd1);
    wait_active(1'b1, "replay_active to rise");
    n = 0;
    while (exp_q.size() != 0 || replay_active || m_valid) begin
      if (n == WAIT_CYCLES) begin
        abort_run($sformatf("timeout in replay, %0d beats still missing", exp_q.size()));
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic zero_count_start();
    write_reg(REG_REPLAY_COUNT, 32'd0);
    write_reg(REG_START, 32'd1);
    repeat (20) begin
      check_value("zero count replay_active", 128'(0), 128'(replay_active));
      check_value("zero count m_valid", 128'(0), 128'(m_valid));
      next_cycle();
    end
  endtask

  // Replay stalled by m_ready held low, then cut short by software reset
  task automatic reset_stalled_replay();
    int n;
    stall_out = 1'b1;
    write_reg(REG_REPLAY_COUNT, 32'd20);
    write_reg(REG_START, 32'd1);
    wait_active(1'b1, "replay_active to rise");
    n = 0;
    while (m_valid !== 1'b1) begin
      if (n == WAIT_CYCLES) begin
        abort_run("timeout waiting for m_valid before software reset");
      end
      next_cycle();
      n++;
    end
    check_value("stalled replay_active", 128'(1), 128'(replay_active));
    write_reg(REG_SW_RST, 32'd1);
    next_cycle();
    write_reg(REG_SW_RST, 32'd0);
    stall_out = 1'b0;
    check_value("sw reset replay_active", 128'(0), 128'(replay_active));
    check_value("sw reset m_valid", 128'(0), 128'(m_valid));
  endtask

  // Transfers are settled half a cycle before the edge that takes them
  always @(negedge axis_aclk) begin
    if (axis_aresetn && m_valid && m_ready) begin
      if (exp_q.size() == 0) begin
        abort_run("output beat appeared while none was expected");
      end else begin
        check_value("output dst port", 128'(DST_PORT), 128'(m_beat.user[15:8]));
        check_value($sformatf("replay beat %0d", beats_out),
                    128'(exp_q.pop_front()), 128'(m_beat));
        beats_out++;
      end
    end
  end

  initial begin
    void'($urandom(32'h57a));
    axis_aresetn   = 1'b0;
    cfg            = '0;
    s_beat         = '0;
    s_valid        = 1'b0;
    m_ready        = 1'b0;
    random_ready   = 1'b0;
    stall_out      = 1'b0;
    beats_out      = 0;
    beats_expected = 0;
    repeat (3) @(posedge axis_aclk);
    #1;
    axis_aresetn = 1'b1;
    check_value("reset m_valid", 128'(0), 128'(m_valid));
    check_value("reset replay_active", 128'(0), 128'(replay_active));
    next_cycle();

    capture(5);
    replay(1);

    random_ready = 1'b1;
    replay(3);
    zero_count_start();

    for (int r = 0; r < 3; r++) begin
      capture(2 + int'($urandom % 5));
      replay(1 + int'($urandom % 3));
    end

    // Long capture, software reset during its stalled replay, then a short one over it
    capture(8);
    reset_stalled_replay();
    capture(2);
    replay(2);

    if (beats_out != beats_expected || exp_q.size() != 0) begin
      abort_run($sformatf("beat count mismatch, %0d seen, %0d expected",
                          beats_out, beats_expected));
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

//--- src/pcap_replay_top.sv
// Packet capture and replay engine
// Captures one source port into an on-chip buffer and replays it on the output stream
`timescale 1ns/1ps

module pcap_replay_top
  import replay_pkg::*;
#(
  parameter int         BUF_ADDR_W       = 6,
  parameter int         FIFO_DEPTH       = 8,
  parameter logic [7:0] CAPTURE_SRC_PORT = 8'h02,
  parameter logic [7:0] REPLAY_DST_PORT  = 8'h01
) (
  input  logic         axis_aclk,
  input  logic         axis_aresetn,
  input  reg_write_t   cfg,
  input  stream_beat_t s_beat,
  input  logic         s_valid,
  output stream_beat_t m_beat,
  output logic         m_valid,
  input  logic         m_ready,
  output logic         replay_active
);

  replay_ctrl_t          ctrl;
  logic                  wr_en;
  logic [BUF_ADDR_W-1:0] wr_addr;
  buf_entry_t            wr_entry;
  logic                  rd_en;
  logic [BUF_ADDR_W-1:0] rd_addr;
  buf_entry_t            rd_entry;
  logic                  push;
  stream_beat_t          push_beat;
  logic                  credit_return;

  replay_regs replay_regs_i (
    .axis_aclk    (axis_aclk),
    .axis_aresetn (axis_aresetn),
    .cfg          (cfg),
    .ctrl         (ctrl)
  );

  capture_writer #(
    .BUF_ADDR_W       (BUF_ADDR_W),
    .CAPTURE_SRC_PORT (CAPTURE_SRC_PORT)
  ) capture_writer_i (
    .axis_aclk    (axis_aclk),
    .axis_aresetn (axis_aresetn),
    .ctrl         (ctrl),
    .s_beat       (s_beat),
    .s_valid      (s_valid),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_entry     (wr_entry)
  );

  pcap_buffer #(
    .BUF_ADDR_W (BUF_ADDR_W)
  ) pcap_buffer_i (
    .axis_aclk (axis_aclk),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_entry  (wr_entry),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_entry  (rd_entry)
  );

  replay_reader #(
    .BUF_ADDR_W (BUF_ADDR_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) replay_reader_i (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .ctrl          (ctrl),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_entry      (rd_entry),
    .push          (push),
    .push_beat     (push_beat),
    .credit_return (credit_return),
    .replay_active (replay_active)
  );

  replay_out_fifo #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .REPLAY_DST_PORT (REPLAY_DST_PORT)
  ) replay_out_fifo_i (
    .axis_aclk     (axis_aclk),
    .axis_aresetn  (axis_aresetn),
    .sw_rst        (ctrl.sw_rst),
    .push          (push),
    .push_beat     (push_beat),
    .m_beat        (m_beat),
    .m_valid       (m_valid),
    .m_ready       (m_ready),
    .credit_return (credit_return)
  );

endmodule

//--- src/replay_out_fifo.sv
// Output FIFO for replayed beats
// Stamps the destination port and returns one credit per beat sent
`timescale 1ns/1ps

module replay_out_fifo
  import replay_pkg::*;
#(
  parameter int         FIFO_DEPTH      = 8,
  parameter logic [7:0] REPLAY_DST_PORT = 8'h01
) (
  input  logic         axis_aclk,
  input  logic         axis_aresetn,
  input  logic         sw_rst,
  input  logic         push,
  input  stream_beat_t push_beat,
  output stream_beat_t m_beat,
  output logic         m_valid,
  input  logic         m_ready,
  output logic         credit_return
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  stream_beat_t     mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign m_valid       = (count != '0);
  assign pop           = m_valid && m_ready;
  assign credit_return = pop;

  always_comb begin
    m_beat            = mem[rd_ptr];
    m_beat.user[15:8] = REPLAY_DST_PORT;
  end

  // Credits keep the writer from ever pushing into a full FIFO
  always_ff @(posedge axis_aclk) begin
    if (push) begin
      mem[wr_ptr] <= push_beat;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn || sw_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/replay_reader.sv
// Replay reader
// Walks the capture buffer for the programmed number of passes, one read per FIFO credit
`timescale 1ns/1ps

module replay_reader
  import replay_pkg::*;
#(
  parameter int BUF_ADDR_W = 6,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                  axis_aclk,
  input  logic                  axis_aresetn,
  input  replay_ctrl_t          ctrl,
  output logic                  rd_en,
  output logic [BUF_ADDR_W-1:0] rd_addr,
  input  buf_entry_t            rd_entry,
  output logic                  push,
  output stream_beat_t          push_beat,
  input  logic                  credit_return,
  output logic                  replay_active
);

  localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

  logic [COUNT_W-1:0] pass_cnt;
  logic [COUNT_W-1:0] pass_nxt;
  logic [CRED_W-1:0]  credits;
  logic [CRED_W-1:0]  credits_nxt;
  logic               rd_pending;
  logic               marker_ret;

  assign marker_ret = rd_pending && rd_entry.end_marker;
  assign pass_nxt   = pass_cnt + 1'b1;

  // No read in the cycle a marker comes back, the address rewinds first
  assign rd_en = replay_active && (credits != '0) && !marker_ret;

  assign push      = rd_pending && !rd_entry.end_marker;
  assign push_beat = rd_entry.beat;

  always_comb begin
    credits_nxt = credits;
    if (rd_en) begin
      credits_nxt = credits_nxt - 1'b1;
    end
    if (credit_return) begin
      credits_nxt = credits_nxt + 1'b1;
    end
    // Marker never reaches the FIFO, so its credit comes straight back
    if (marker_ret) begin
      credits_nxt = credits_nxt + 1'b1;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn || ctrl.sw_rst) begin
      replay_active <= 1'b0;
      rd_addr       <= '0;
      pass_cnt      <= '0;
      credits       <= CRED_W'(FIFO_DEPTH);
      rd_pending    <= 1'b0;
    end else begin
      credits    <= credits_nxt;
      rd_pending <= rd_en;

      if (!replay_active) begin
        if (ctrl.start_pulse && (ctrl.replay_count != '0)) begin
          replay_active <= 1'b1;
          rd_addr       <= '0;
          pass_cnt      <= '0;
        end
      end else if (marker_ret) begin
        rd_addr  <= '0;
        pass_cnt <= pass_nxt;
        if (pass_nxt >= ctrl.replay_count) begin
          replay_active <= 1'b0;
        end
      end else if (rd_en) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

endmodule

//--- src/pcap_buffer.sv
// Capture buffer
// Single write port, registered read port with one cycle of latency
`timescale 1ns/1ps

module pcap_buffer
  import replay_pkg::*;
#(
  parameter int BUF_ADDR_W = 6
) (
  input  logic                  axis_aclk,
  input  logic                  wr_en,
  input  logic [BUF_ADDR_W-1:0] wr_addr,
  input  buf_entry_t            wr_entry,
  input  logic                  rd_en,
  input  logic [BUF_ADDR_W-1:0] rd_addr,
  output buf_entry_t            rd_entry
);

  localparam int DEPTH = 2 ** BUF_ADDR_W;

  buf_entry_t mem [DEPTH];

  always_ff @(posedge axis_aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_entry;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (rd_en) begin
      rd_entry <= mem[rd_addr];
    end
  end

endmodule

//--- src/capture_writer.sv
// Capture writer
// Filters input beats by source port and appends them to the capture buffer
`timescale 1ns/1ps

module capture_writer
  import replay_pkg::*;
#(
  parameter int         BUF_ADDR_W       = 6,
  parameter logic [7:0] CAPTURE_SRC_PORT = 8'h02
) (
  input  logic                  axis_aclk,
  input  logic                  axis_aresetn,
  input  replay_ctrl_t          ctrl,
  input  stream_beat_t          s_beat,
  input  logic                  s_valid,
  output logic                  wr_en,
  output logic [BUF_ADDR_W-1:0] wr_addr,
  output buf_entry_t            wr_entry
);

  typedef enum logic {
    WR_IDLE,
    WR_CAPTURE
  } wr_state_t;

  wr_state_t             state;
  logic [BUF_ADDR_W-1:0] next_addr;
  logic                  match;
  logic                  close;

  assign match = s_valid && (s_beat.user[7:0] == CAPTURE_SRC_PORT);
  assign close = (state == WR_CAPTURE) && ctrl.capture_done_pulse;

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn || ctrl.sw_rst) begin
      state     <= WR_IDLE;
      next_addr <= '0;
      wr_en     <= 1'b0;
      wr_addr   <= '0;
    end else begin
      wr_en <= 1'b0;
      case (state)
        WR_IDLE: begin
          // New capture always restarts at the bottom of the buffer
          if (match) begin
            wr_en     <= 1'b1;
            wr_addr   <= '0;
            next_addr <= BUF_ADDR_W'(1);
            state     <= WR_CAPTURE;
          end
        end
        WR_CAPTURE: begin
          if (close) begin
            wr_en   <= 1'b1;
            wr_addr <= next_addr;
            state   <= WR_IDLE;
          end else if (match && (next_addr != '1)) begin
            // Last address is kept free for the end marker
            wr_en     <= 1'b1;
            wr_addr   <= next_addr;
            next_addr <= next_addr + 1'b1;
          end
        end
        default: begin
          state <= WR_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge axis_aclk) begin
    wr_entry.end_marker <= close;
    wr_entry.beat       <= close ? '0 : s_beat;
  end

endmodule

//--- src/replay_regs.sv
// Control register block
// Holds software reset and replay count, turns start and done writes into pulses
`timescale 1ns/1ps

module replay_regs
  import replay_pkg::*;
(
  input  logic         axis_aclk,
  input  logic         axis_aresetn,
  input  reg_write_t   cfg,
  output replay_ctrl_t ctrl
);

  always_ff @(posedge axis_aclk) begin
    if (!axis_aresetn) begin
      ctrl <= '0;
    end else begin
      // Pulses last a single cycle
      ctrl.start_pulse        <= 1'b0;
      ctrl.capture_done_pulse <= 1'b0;

      if (cfg.valid) begin
        case (cfg.addr)
          REG_SW_RST: begin
            ctrl.sw_rst <= cfg.data[0];
          end
          REG_START: begin
            ctrl.start_pulse <= cfg.data[0];
          end
          REG_REPLAY_COUNT: begin
            ctrl.replay_count <= cfg.data[COUNT_W-1:0];
          end
          REG_WR_DONE: begin
            ctrl.capture_done_pulse <= cfg.data[0];
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

//--- src/replay_pkg.sv
// Capture and replay engine shared definitions
// Stream widths, register map and the structs passed between blocks
package replay_pkg;

  localparam int DATA_W  = 64;
  localparam int KEEP_W  = DATA_W / 8;
  localparam int USER_W  = 16;
  localparam int COUNT_W = 16;

  // Register map
  localparam logic [3:0] REG_SW_RST       = 4'h0;
  localparam logic [3:0] REG_START        = 4'h4;
  localparam logic [3:0] REG_REPLAY_COUNT = 4'h8;
  localparam logic [3:0] REG_WR_DONE      = 4'hC;

  // User bits 7:0 carry the source port, 15:8 the destination port
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic [USER_W-1:0] user;
    logic              last;
  } stream_beat_t;

  typedef struct packed {
    logic         end_marker;
    stream_beat_t beat;
  } buf_entry_t;

  typedef struct packed {
    logic        valid;
    logic [3:0]  addr;
    logic [31:0] data;
  } reg_write_t;

  typedef struct packed {
    logic               sw_rst;
    logic               start_pulse;
    logic               capture_done_pulse;
    logic [COUNT_W-1:0] replay_count;
  } replay_ctrl_t;

endpackage
